/* bench/tb_clk_gen.sv */
// free-running testbench clock, period 4; rs is released on the second rising edge
`default_nettype none

module tb_clk_gen (
  output logic ck933_o,
  output logic rs_o
);

  localparam int HALF_PERIOD = 2;

  initial ck933_o = 1'b0;

  always #(HALF_PERIOD) ck933_o = ~ck933_o;

  // two cycles of reset
  initial begin
    rs_o = 1'b1;
    repeat (2) @(posedge ck933_o);
    rs_o <= 1'b0;
  end

endmodule

`default_nettype wire

/* bench/tb_top.sv */
// directed tests of the wrapper; the run stops at the first wrong value or at 3000 cycles
`default_nettype none

`include "trellis_consts.svh"

module tb_top;

  import trellis_pkg::*;

  localparam int TIMEOUT_CYCLES = 3000;  // all tests with margin

  logic                       ck933;
  logic                       rs;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  reg_addr_t                  paddr;
  reg_data_t                  pwdata;
  reg_data_t                  prdata;
  logic                       pslverr;
  dac_sample_t [`DAC_NUM-1:0] dac_sample;
  logic [`DAC_NUM-1:0]        dac_sync;
  dac_code_t [`DAC_NUM-1:0]   dac_d;
  logic [`DAC_NUM-1:0]        dac_n_cs;
  logic                       dac_sclk;
  logic                       dac_sdio;
  logic                       dac_rst;

  int cycles = 0;

  tb_clk_gen u_clk_gen (
    .ck933_o (ck933),
    .rs_o    (rs)
  );

  trellis_top UUT (
    .ck933        (ck933),
    .rs           (rs),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pslverr_o    (pslverr),
    .dac_sample_i (dac_sample),
    .dac_sync_i   (dac_sync),
    .dac_d_o      (dac_d),
    .dac_n_cs_o   (dac_n_cs),
    .dac_sclk_o   (dac_sclk),
    .dac_sdio_o   (dac_sdio),
    .dac_rst_o    (dac_rst)
  );

  // **************************************************
  // reporting and bus tasks
  // **************************************************

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_error(input string msg);
    stop_run($sformatf("FAIL at %0t: %s", $time, msg));
  endtask

  always @(posedge ck933) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      stop_run($sformatf("simulation timed out after %0d cycles", cycles));
    end
  end

  task automatic apb_write(input reg_addr_t addr, input reg_data_t data, output logic err);
    @(posedge ck933);
    psel    <= 1'b1;  // setup
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge ck933);
    penable <= 1'b1;  // access
    @(negedge ck933);
    err = pslverr;
    @(posedge ck933);  // write lands on this edge
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input reg_addr_t addr, output reg_data_t data, output logic err);
    @(posedge ck933);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge ck933);
    penable <= 1'b1;
    @(negedge ck933);
    data = prdata;
    err  = pslverr;
    @(posedge ck933);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // sign bit flipped, low four bits dropped
  function automatic dac_code_t offset_code(input logic [17:0] smp, input logic en);
    if (en) begin
      return smp[17:4] ^ 14'h2000;
    end
    return 14'h2000;
  endfunction

  // **************************************************
  // tests
  // **************************************************

  task automatic reset_state();
    int        hi;
    reg_data_t rd;
    logic      err;
    hi = 0;
    @(negedge rs);
    for (int c = 0; c < 20; c++) begin
      @(negedge ck933);
      if (!dac_rst) break;
      hi++;
    end
    assert (hi == `RESET_STRETCH)
      else report_error($sformatf("dac_rst_o high for %0d cycles after rs, expected 6", hi));
    assert (dac_n_cs == 3'b111 && !dac_sclk && !dac_sdio)
      else report_error("serial pins not idle after reset");
    for (int n = 0; n < `DAC_NUM; n++) begin
      assert (dac_d[n] == 14'h2000)
        else report_error($sformatf("dac_d[%0d] = %h after reset", n, dac_d[n]));
    end
    apb_read({4'h0, `MISC_VERSION_OFS}, rd, err);
    assert (rd == 16'h0032 && !err) else report_error($sformatf("version read %h", rd));
    apb_read({4'h1, `DAC_STATUS_OFS}, rd, err);
    assert (rd == '0) else report_error($sformatf("status read %h after reset", rd));
    apb_read({4'h2, `DAC_OUT_EN_OFS}, rd, err);
    assert (rd == '0) else report_error($sformatf("enable mask read %h after reset", rd));
  endtask

  task automatic address_errors();
    reg_data_t rd;
    reg_addr_t addr;
    logic      err;
    for (int sp = 3; sp < 16; sp++) begin
      addr = {4'(sp), 7'($urandom), 1'b0};
      apb_write(addr, reg_data_t'($urandom), err);
      assert (err) else report_error($sformatf("no pslverr on write to %h", addr));
      apb_read(addr, rd, err);
      assert (err && rd == '0)
        else report_error($sformatf("read of %h gave err %b data %h", addr, err, rd));
    end
    for (int sp = 0; sp < 3; sp++) begin
      for (int ofs = 0; ofs < 8; ofs += 2) begin
        apb_read({4'(sp), 8'(ofs)}, rd, err);
        assert (!err) else report_error($sformatf("pslverr in space %0d", sp));
      end
      apb_write({4'(sp), 8'h20}, reg_data_t'($urandom), err);  // unused offset
      assert (!err) else report_error($sformatf("pslverr on write in space %0d", sp));
    end
  endtask

  task automatic soft_reset();
    int        hi;
    reg_data_t rd;
    logic      err;
    hi = 0;
    apb_write({4'h2, `DAC_OUT_EN_OFS}, 16'h0005, err);
    apb_read({4'h2, `DAC_OUT_EN_OFS}, rd, err);
    assert (rd == 16'h0005) else report_error($sformatf("enable mask read %h", rd));
    apb_write({4'h0, `MISC_RESET_OFS}, 16'h0001, err);
    for (int c = 0; c < 20; c++) begin
      @(negedge ck933);
      if (!dac_rst) break;
      hi++;
    end
    assert (hi == `RESET_STRETCH)
      else report_error($sformatf("soft reset lasted %0d cycles, expected 6", hi));
    apb_read({4'h2, `DAC_OUT_EN_OFS}, rd, err);
    assert (rd == '0) else report_error($sformatf("mask %h survived soft reset", rd));
  endtask

  task automatic serial_transfer(input int sel);
    reg_data_t word;
    reg_data_t got;
    reg_data_t rd;
    int        nbits;
    int        polls;
    logic      err;
    logic      prev_sclk;
    word      = reg_data_t'($urandom);
    got       = '0;
    nbits     = 0;
    polls     = 0;
    prev_sclk = 1'b0;
    apb_write({4'h1, `DAC_SEL_OFS}, reg_data_t'(sel), err);
    apb_write({4'h1, `DAC_DATA_OFS}, word, err);
    fork
      begin : watch_pins
        for (int c = 0; c < 200; c++) begin
          @(negedge ck933);
          if (dac_n_cs[sel]) break;  // transfer over
          assert ((dac_n_cs | 3'(1 << sel)) == 3'b111)
            else report_error($sformatf("chip selects %b during transfer to %0d", dac_n_cs, sel));
          if (dac_sclk && !prev_sclk) begin
            got = {got[14:0], dac_sdio};
            nbits++;
          end
          prev_sclk = dac_sclk;
        end
      end
      begin : poll_status
        repeat (4) @(posedge ck933);
        apb_write({4'h1, `DAC_DATA_OFS}, ~word, err);  // should be dropped
        apb_read({4'h1, `DAC_STATUS_OFS}, rd, err);
        assert (rd[0]) else report_error("busy clear during transfer");
        while (rd[0] && polls < 100) begin
          apb_read({4'h1, `DAC_STATUS_OFS}, rd, err);
          polls++;
        end
        assert (!rd[0]) else report_error("busy never cleared");
      end
    join
    assert (nbits == 16) else report_error($sformatf("%0d sclk edges, expected 16", nbits));
    assert (got == word) else report_error($sformatf("shifted %h, expected %h", got, word));
    apb_read({4'h1, `DAC_DATA_OFS}, rd, err);
    assert (rd == word) else report_error($sformatf("data reg %h, expected %h", rd, word));
  endtask

  task automatic output_format(input int rounds);
    logic [`DAC_NUM-1:0] mask;
    logic [`DAC_NUM-1:0] strobe;
    logic [17:0]         smp;
    dac_code_t           exp [`DAC_NUM];
    reg_data_t           rd;
    logic                err;
    for (int n = 0; n < `DAC_NUM; n++) begin
      exp[n] = 14'h2000;  // cleared by the soft reset, no strobe since
    end
    for (int r = 0; r < rounds; r++) begin
      mask = 3'($urandom);
      apb_write({4'h2, `DAC_OUT_EN_OFS}, reg_data_t'(mask), err);
      apb_read({4'h2, `DAC_OUT_EN_OFS}, rd, err);
      assert (rd == reg_data_t'(mask)) else report_error($sformatf("mask read %h", rd));
      for (int i = 0; i < 20; i++) begin
        @(posedge ck933);
        strobe = 3'($urandom);
        for (int n = 0; n < `DAC_NUM; n++) begin
          smp = 18'($urandom);
          dac_sample[n] <= smp;
          if (strobe[n]) exp[n] = offset_code(smp, mask[n]);
        end
        dac_sync <= strobe;
        @(posedge ck933);  // captured here
        dac_sync <= '0;
        @(negedge ck933);
        for (int n = 0; n < `DAC_NUM; n++) begin
          assert (dac_d[n] == exp[n])
            else report_error($sformatf("dac_d[%0d] = %h, expected %h", n, dac_d[n], exp[n]));
        end
      end
    end
  endtask

  // **************************************************
  // sequence
  // **************************************************

  initial begin
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    dac_sample = '0;
    dac_sync   = '0;
    void'($urandom(32'h02ec_f507));
    reset_state();
    address_errors();
    soft_reset();
    for (int s = 0; s < `DAC_NUM; s++) begin
      serial_transfer(s);
      serial_transfer(s);
    end
    output_format(2);
    if (UUT.u_trellis_sva.err_cnt == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_run("bound assertions on the DUT pins failed");
    end
  end

endmodule

`default_nettype wire

/* bench/trellis_sva.sv */
// bound to trellis_top; the chip select and sclk checks are off while rs is high
`default_nettype none

`include "trellis_consts.svh"

module trellis_sva (
  input logic                ck933_i,
  input logic                rs_i,
  input logic                psel_i,
  input logic                penable_i,
  input logic                pslverr_i,
  input logic [`DAC_NUM-1:0] dac_n_cs_i,
  input logic                dac_sclk_i
);

  int err_cnt = 0;  // failed assertions so far

  // **************************************************
  // DAC serial pins
  // **************************************************

  // one DAC at a time
  cs_onehot: assert property (@(posedge ck933_i) disable iff (rs_i)
    $onehot0(~dac_n_cs_i))
    else begin
      $error("more than one DAC chip select is low");
      err_cnt++;
    end

  // no clock without a selected DAC
  sclk_idle: assert property (@(posedge ck933_i) disable iff (rs_i)
    (&dac_n_cs_i) |-> !dac_sclk_i)
    else begin
      $error("dac_sclk_o high with all chip selects high");
      err_cnt++;
    end

  // **************************************************
  // APB
  // **************************************************

  slverr_phase: assert property (@(posedge ck933_i)
    pslverr_i |-> (psel_i && penable_i))
    else begin
      $error("pslverr_o outside the access phase");
      err_cnt++;
    end

endmodule

bind trellis_top trellis_sva u_trellis_sva (
  .ck933_i    (ck933),
  .rs_i       (rs),
  .psel_i     (psel_i),
  .penable_i  (penable_i),
  .pslverr_i  (pslverr_o),
  .dac_n_cs_i (dac_n_cs_o),
  .dac_sclk_i (dac_sclk_o)
);

`default_nettype wire

/* common/trellis_consts.svh */
// register map and sizing constants; DAC_SCLK_DIV must be even and at least 4
`ifndef TRELLIS_CONSTS_SVH
`define TRELLIS_CONSTS_SVH

// version register contents
`define TRELLIS_VERSION   16'h0032

// core reset length in ck933 cycles
`define RESET_STRETCH     6

// serial port, ck933 cycles per sclk period
`define DAC_SCLK_DIV      4
`define DAC_WORD_BITS     16

// number of DAC channels
`define DAC_NUM           3

// code driven when a channel is off
`define DAC_MIDSCALE      14'h2000

// misc space
`define MISC_VERSION_OFS  8'h00
`define MISC_RESET_OFS    8'h02

// dac serial space
`define DAC_SEL_OFS       8'h00
`define DAC_DATA_OFS      8'h02
`define DAC_STATUS_OFS    8'h04

// dac output space
`define DAC_OUT_EN_OFS    8'h00

`endif

/* common/trellis_pkg.sv */
// shared bus, sample and code types; widths are fixed here and must track the register map
`default_nettype none

package trellis_pkg;

  // **************************************************
  // host register bus
  // **************************************************

  typedef logic [11:0] reg_addr_t;    // byte address, bit 0 unused
  typedef logic [15:0] reg_data_t;
  typedef logic [7:0]  reg_offset_t;  // offset inside one space

  // decoded from paddr[11:8]
  typedef enum logic [1:0] {
    SPACE_MISC       = 2'd0,
    SPACE_DAC_SERIAL = 2'd1,
    SPACE_DAC_OUT    = 2'd2,
    SPACE_NONE       = 2'd3
  } reg_space_e;

  // **************************************************
  // sample path
  // **************************************************

  typedef logic signed [17:0] dac_sample_t;  // two's complement from demod
  typedef logic [13:0]        dac_code_t;    // offset binary at the pins

endpackage

`default_nettype wire

/* dac_out/dac_out_bank.sv */
// samples are taken only on their sync strobe; the low four sample bits are dropped
`default_nettype none

`include "trellis_consts.svh"

module dac_out_bank (
  input  logic                                     ck933,
  input  logic                                     rs_i,
  input  logic                                     sel_i,
  input  logic                                     reg_wr_i,
  input  trellis_pkg::reg_offset_t                 reg_offset_i,
  input  trellis_pkg::reg_data_t                   reg_wdata_i,
  output trellis_pkg::reg_data_t                   rdata_o,
  input  trellis_pkg::dac_sample_t [`DAC_NUM-1:0]  dac_sample_i,
  input  logic [`DAC_NUM-1:0]                      dac_sync_i,
  output trellis_pkg::dac_code_t [`DAC_NUM-1:0]    dac_d_o
);

  import trellis_pkg::*;

  localparam int SW = $bits(dac_sample_t);
  localparam int CW = $bits(dac_code_t);

  logic [`DAC_NUM-1:0] en_q;  // one bit per channel

  // **************************************************
  // enable register
  // **************************************************

  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      en_q <= '0;
    end else if (sel_i && reg_wr_i && (reg_offset_i == `DAC_OUT_EN_OFS)) begin
      en_q <= reg_wdata_i[`DAC_NUM-1:0];
    end
  end

  always_comb begin
    rdata_o = '0;
    if (reg_offset_i == `DAC_OUT_EN_OFS) begin
      rdata_o[`DAC_NUM-1:0] = en_q;
    end
  end

  // **************************************************
  // output registers
  // **************************************************

  for (genvar n = 0; n < `DAC_NUM; n++) begin : g_chan
    dac_code_t code;

    // flip the sign bit for offset binary, top CW bits of the sample
    always_comb begin
      if (en_q[n]) begin
        code = {~dac_sample_i[n][SW-1], dac_sample_i[n][SW-2 -: CW-1]};
      end else begin
        code = `DAC_MIDSCALE;  // channel off
      end
    end

    always_ff @(posedge ck933 or posedge rs_i) begin
      if (rs_i) begin
        dac_d_o[n] <= `DAC_MIDSCALE;
      end else if (dac_sync_i[n]) begin
        dac_d_o[n] <= code;  // holds between strobes
      end
    end
  end

endmodule

`default_nettype wire

/* dac_serial/dac_serial_port.sv */
// write-only serial port, select 3 sends the word with no chip select and sclk held low
`default_nettype none

`include "trellis_consts.svh"

module dac_serial_port (
  input  logic                     ck933,
  input  logic                     rs_i,
  input  logic                     sel_i,
  input  logic                     reg_wr_i,
  input  trellis_pkg::reg_offset_t reg_offset_i,
  input  trellis_pkg::reg_data_t   reg_wdata_i,
  output trellis_pkg::reg_data_t   rdata_o,
  output logic [`DAC_NUM-1:0]      dac_n_cs_o,
  output logic                     dac_sclk_o,
  output logic                     dac_sdio_o
);

  localparam int DIV   = `DAC_SCLK_DIV;
  localparam int DIV_W = $clog2(DIV);
  localparam int HALF  = DIV / 2;
  localparam int WORD  = `DAC_WORD_BITS;
  localparam int BIT_W = $clog2(WORD);
  localparam int SEL_W = $clog2(`DAC_NUM);

  logic [SEL_W-1:0]    dac_sel;
  logic [WORD-1:0]     dac_data;   // last word written, for read back
  logic [WORD-1:0]     shreg;
  logic                busy;
  logic [DIV_W-1:0]    div;        // phase inside one sclk period
  logic [BIT_W-1:0]    bit_cnt;    // bits left after the current one
  logic [`DAC_NUM-1:0] cs_mask_n;  // chip selects for the current dac_sel
  logic                div_last;
  logic                sel_ok;
  logic                start;

  assign div_last = (div == DIV_W'(DIV - 1));
  assign sel_ok   = ~&dac_n_cs_o;  // a DAC is actually selected
  assign start    = sel_i & reg_wr_i & (reg_offset_i == `DAC_DATA_OFS) & ~busy;

  always_comb begin
    for (int n = 0; n < `DAC_NUM; n++) begin
      cs_mask_n[n] = (dac_sel != SEL_W'(n));
    end
  end

  // **************************************************
  // config registers
  // **************************************************

  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      dac_sel  <= '0;
      dac_data <= '0;
    end else if (sel_i && reg_wr_i) begin
      if (reg_offset_i == `DAC_SEL_OFS) begin
        dac_sel <= reg_wdata_i[SEL_W-1:0];
      end
      if (start) begin
        dac_data <= reg_wdata_i[WORD-1:0];  // held while busy
      end
    end
  end

  // **************************************************
  // shifter
  // **************************************************

  // sclk high for phases 1..HALF, sdio moves at the wrap while sclk is low
  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      busy       <= 1'b0;
      div        <= '0;
      bit_cnt    <= '0;
      dac_n_cs_o <= '1;
      dac_sclk_o <= 1'b0;
      dac_sdio_o <= 1'b0;
    end else if (start) begin
      busy       <= 1'b1;
      div        <= '0;
      bit_cnt    <= BIT_W'(WORD - 1);
      dac_n_cs_o <= cs_mask_n;
      dac_sclk_o <= 1'b0;
      dac_sdio_o <= reg_wdata_i[WORD-1];  // MSB first
    end else if (busy) begin
      div        <= div_last ? '0 : div + 1'b1;
      dac_sclk_o <= sel_ok && (div < DIV_W'(HALF));
      if (div_last) begin
        if (bit_cnt == '0) begin
          busy       <= 1'b0;  // cs rises one cycle after the last fall
          dac_n_cs_o <= '1;
          dac_sdio_o <= 1'b0;
        end else begin
          bit_cnt    <= bit_cnt - 1'b1;
          dac_sdio_o <= shreg[WORD-2];
        end
      end
    end
  end

  // data path only
  always_ff @(posedge ck933) begin
    if (start) begin
      shreg <= reg_wdata_i[WORD-1:0];
    end else if (busy && div_last) begin
      shreg <= shreg << 1;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (reg_offset_i)
      `DAC_SEL_OFS:    rdata_o[SEL_W-1:0] = dac_sel;
      `DAC_DATA_OFS:   rdata_o[WORD-1:0]  = dac_data;
      `DAC_STATUS_OFS: rdata_o[0]         = busy;
      default:         rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/apb_decode.sv */
// purely combinational, no pready; every access completes in its first access cycle
`default_nettype none

module apb_decode (
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  trellis_pkg::reg_addr_t   paddr_i,
  input  trellis_pkg::reg_data_t   pwdata_i,
  input  trellis_pkg::reg_data_t   misc_rdata_i,
  input  trellis_pkg::reg_data_t   ser_rdata_i,
  input  trellis_pkg::reg_data_t   out_rdata_i,
  output trellis_pkg::reg_data_t   prdata_o,
  output logic                     pslverr_o,
  output logic                     reg_wr_o,
  output trellis_pkg::reg_offset_t reg_offset_o,
  output trellis_pkg::reg_data_t   reg_wdata_o,
  output logic                     misc_sel_o,
  output logic                     ser_sel_o,
  output logic                     out_sel_o
);

  import trellis_pkg::*;

  reg_space_e space;
  logic       access;  // second cycle of the transfer

  // space from the upper address nibble
  always_comb begin
    case (paddr_i[11:8])
      4'd0:    space = SPACE_MISC;
      4'd1:    space = SPACE_DAC_SERIAL;
      4'd2:    space = SPACE_DAC_OUT;
      default: space = SPACE_NONE;
    endcase
  end

  assign access = psel_i & penable_i;

  assign misc_sel_o = psel_i & (space == SPACE_MISC);
  assign ser_sel_o  = psel_i & (space == SPACE_DAC_SERIAL);
  assign out_sel_o  = psel_i & (space == SPACE_DAC_OUT);

  // blocks qualify the strobe with their own select
  assign reg_wr_o     = access & pwrite_i;
  assign reg_offset_o = paddr_i[7:0];
  assign reg_wdata_o  = pwdata_i;

  // **************************************************
  // read mux and error
  // **************************************************

  always_comb begin
    prdata_o = '0;
    if (psel_i) begin
      case (space)
        SPACE_MISC:       prdata_o = misc_rdata_i;
        SPACE_DAC_SERIAL: prdata_o = ser_rdata_i;
        SPACE_DAC_OUT:    prdata_o = out_rdata_i;
        default:          prdata_o = '0;  // unmapped reads zero
      endcase
    end
  end

  assign pslverr_o = access & (space == SPACE_NONE);  // reads and writes alike

endmodule

`default_nettype wire

/* design/misc_regs.sv */
// any write to the reset offset restarts the stretch, the written data is ignored
`default_nettype none

`include "trellis_consts.svh"

module misc_regs (
  input  logic                     ck933,
  input  logic                     rs,
  input  logic                     sel_i,
  input  logic                     reg_wr_i,
  input  trellis_pkg::reg_offset_t reg_offset_i,
  input  trellis_pkg::reg_data_t   reg_wdata_i,
  output trellis_pkg::reg_data_t   rdata_o,
  output logic                     core_rst_o
);

  import trellis_pkg::*;

  localparam int CNT_W = $clog2(`RESET_STRETCH + 1);

  logic [CNT_W-1:0] stretch_cnt;  // cycles left after the current one
  logic             soft_rst_wr;

  assign soft_rst_wr = sel_i & reg_wr_i & (reg_offset_i == `MISC_RESET_OFS);

  // **************************************************
  // reset stretcher
  // **************************************************

  // high through rs, then RESET_STRETCH more edges
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      core_rst_o  <= 1'b1;
      stretch_cnt <= CNT_W'(`RESET_STRETCH - 1);
    end else if (soft_rst_wr) begin
      core_rst_o  <= 1'b1;  // rises on the write edge
      stretch_cnt <= CNT_W'(`RESET_STRETCH - 1);
    end else if (stretch_cnt != '0) begin
      stretch_cnt <= stretch_cnt - 1'b1;
    end else begin
      core_rst_o <= 1'b0;
    end
  end

  // read back, reset offset shows the stretch still running
  always_comb begin
    rdata_o = '0;
    case (reg_offset_i)
      `MISC_VERSION_OFS: rdata_o = reg_data_t'(`TRELLIS_VERSION);
      `MISC_RESET_OFS:   rdata_o[0] = core_rst_o;
      default:           rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/trellis_top.sv */
// zero-wait APB slave; DAC clock pins are not driven here and come from ck933 on the board
`default_nettype none

`include "trellis_consts.svh"

module trellis_top (
  input  logic                                     ck933,
  input  logic                                     rs,
  // host bus
  input  logic                                     psel_i,
  input  logic                                     penable_i,
  input  logic                                     pwrite_i,
  input  trellis_pkg::reg_addr_t                   paddr_i,
  input  trellis_pkg::reg_data_t                   pwdata_i,
  output trellis_pkg::reg_data_t                   prdata_o,
  output logic                                     pslverr_o,
  // samples from the demod
  input  trellis_pkg::dac_sample_t [`DAC_NUM-1:0]  dac_sample_i,
  input  logic [`DAC_NUM-1:0]                      dac_sync_i,
  // DAC pins
  output trellis_pkg::dac_code_t [`DAC_NUM-1:0]    dac_d_o,
  output logic [`DAC_NUM-1:0]                      dac_n_cs_o,
  output logic                                     dac_sclk_o,
  output logic                                     dac_sdio_o,
  output logic                                     dac_rst_o
);

  import trellis_pkg::*;

  logic        reg_wr;
  reg_offset_t reg_offset;
  reg_data_t   reg_wdata;

  logic      misc_sel, ser_sel, out_sel;
  reg_data_t misc_rdata, ser_rdata, out_rdata;

  logic core_rst;  // stretched reset for everything but the bus

  // **************************************************
  // bus decode
  // **************************************************

  apb_decode u_apb_decode (
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .misc_rdata_i (misc_rdata),
    .ser_rdata_i  (ser_rdata),
    .out_rdata_i  (out_rdata),
    .prdata_o     (prdata_o),
    .pslverr_o    (pslverr_o),
    .reg_wr_o     (reg_wr),
    .reg_offset_o (reg_offset),
    .reg_wdata_o  (reg_wdata),
    .misc_sel_o   (misc_sel),
    .ser_sel_o    (ser_sel),
    .out_sel_o    (out_sel)
  );

  // **************************************************
  // misc space, version and reset
  // **************************************************

  misc_regs u_misc_regs (
    .ck933        (ck933),
    .rs           (rs),
    .sel_i        (misc_sel),
    .reg_wr_i     (reg_wr),
    .reg_offset_i (reg_offset),
    .reg_wdata_i  (reg_wdata),
    .rdata_o      (misc_rdata),
    .core_rst_o   (core_rst)
  );

  assign dac_rst_o = core_rst;  // DACs share the core reset

  // **************************************************
  // DAC serial config port
  // **************************************************

  dac_serial_port u_dac_serial_port (
    .ck933        (ck933),
    .rs_i         (core_rst),
    .sel_i        (ser_sel),
    .reg_wr_i     (reg_wr),
    .reg_offset_i (reg_offset),
    .reg_wdata_i  (reg_wdata),
    .rdata_o      (ser_rdata),
    .dac_n_cs_o   (dac_n_cs_o),
    .dac_sclk_o   (dac_sclk_o),
    .dac_sdio_o   (dac_sdio_o)
  );

  // **************************************************
  // DAC sample outputs
  // **************************************************

  dac_out_bank u_dac_out_bank (
    .ck933        (ck933),
    .rs_i         (core_rst),
    .sel_i        (out_sel),
    .reg_wr_i     (reg_wr),
    .reg_offset_i (reg_offset),
    .reg_wdata_i  (reg_wdata),
    .rdata_o      (out_rdata),
    .dac_sample_i (dac_sample_i),
    .dac_sync_i   (dac_sync_i),
    .dac_d_o      (dac_d_o)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -q "^Testbench passed$" "$LOG"
if [ $? -ne 0 ]; then
  echo "pass line not found in $LOG"
  exit 1
fi

echo "simulation passed"
exit 0

/* tb.f */
+incdir+common
common/trellis_pkg.sv
design/apb_decode.sv
design/misc_regs.sv
dac_serial/dac_serial_port.sv
dac_out/dac_out_bank.sv
design/trellis_top.sv
bench/tb_clk_gen.sv
bench/trellis_sva.sv
bench/tb_top.sv
